//--- compile.f
+incdir+verilog
verilog/itf_pkg.sv
verilog/itf_link_ctrl.sv
verilog/itf_in_fifo.sv
verilog/itf_in_steer.sv
verilog/itf_out_mux.sv
verilog/itf_top.sv
dv/itf_assert.sv
dv/itf_tb.sv

//--- Bender.yml
package:
  name: itf

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/itf_pkg.sv
      - verilog/itf_link_ctrl.sv
      - verilog/itf_in_fifo.sv
      - verilog/itf_in_steer.sv
      - verilog/itf_out_mux.sv
      - verilog/itf_top.sv
  - target: simulation
    files:
      - dv/itf_assert.sv
      - dv/itf_tb.sv

//--- dv/itf_tb.sv
`default_nettype none

module itf_tb;

    localparam int TIMEOUT_CYCLES = 2000;

    logic                  OffClk;
    logic                  rst_n;
    itf_pkg::itf_dat_t     off_dat_i;
    logic                  off_dat_vld_i;
    logic                  off_dat_last_i;
    logic                  off_isa_vld_i;
    logic                  off_dat_rdy_i;
    logic                  off_oe_i;
    logic                  byp_oe_i;
    itf_pkg::itf_dat_t     off_dat_o;
    logic                  off_dat_vld_o;
    logic                  off_dat_last_o;
    logic                  off_cmd_vld_o;
    logic                  off_in_rdy_o;
    logic                  off_dat_oe_o;
    itf_pkg::itf_mon_t     mon_state_o;
    itf_pkg::itf_cfg_rdy_t cfg_rdy_o;
    itf_pkg::itf_cfg_rdy_t ccu_cfg_rdy_i;
    itf_pkg::itf_ccu_mon_t ccu_mon_state_i;
    itf_pkg::itf_dat_t     ccu_dat_o;
    logic                  ccu_dat_vld_o;
    logic                  ccu_dat_last_o;
    logic                  ccu_dat_rdy_i;
    itf_pkg::itf_dat_t     gic_dat_o;
    logic                  gic_dat_vld_o;
    logic                  gic_dat_last_o;
    logic                  gic_dat_rdy_i;
    itf_pkg::itf_dat_t     gic_dat_i;
    logic                  gic_dat_vld_i;
    logic                  gic_dat_last_i;
    logic                  gic_cmd_vld_i;
    logic                  gic_dat_rdy_o;
    itf_pkg::itf_dat_t     mon_dat_i;
    logic                  mon_dat_vld_i;
    logic                  mon_dat_last_i;
    logic                  mon_dat_rdy_o;

    integer seed;
    int     cycle_cnt = 0;
    // Inbound beats taken by the link so far
    int     in_cnt = 0;

    itf_top i_itf_top (
        .OffClk          (OffClk),
        .rst_n           (rst_n),
        .off_dat_i       (off_dat_i),
        .off_dat_vld_i   (off_dat_vld_i),
        .off_dat_last_i  (off_dat_last_i),
        .off_isa_vld_i   (off_isa_vld_i),
        .off_dat_rdy_i   (off_dat_rdy_i),
        .off_oe_i        (off_oe_i),
        .byp_oe_i        (byp_oe_i),
        .off_dat_o       (off_dat_o),
        .off_dat_vld_o   (off_dat_vld_o),
        .off_dat_last_o  (off_dat_last_o),
        .off_cmd_vld_o   (off_cmd_vld_o),
        .off_in_rdy_o    (off_in_rdy_o),
        .off_dat_oe_o    (off_dat_oe_o),
        .mon_state_o     (mon_state_o),
        .cfg_rdy_o       (cfg_rdy_o),
        .ccu_cfg_rdy_i   (ccu_cfg_rdy_i),
        .ccu_mon_state_i (ccu_mon_state_i),
        .ccu_dat_o       (ccu_dat_o),
        .ccu_dat_vld_o   (ccu_dat_vld_o),
        .ccu_dat_last_o  (ccu_dat_last_o),
        .ccu_dat_rdy_i   (ccu_dat_rdy_i),
        .gic_dat_o       (gic_dat_o),
        .gic_dat_vld_o   (gic_dat_vld_o),
        .gic_dat_last_o  (gic_dat_last_o),
        .gic_dat_rdy_i   (gic_dat_rdy_i),
        .gic_dat_i       (gic_dat_i),
        .gic_dat_vld_i   (gic_dat_vld_i),
        .gic_dat_last_i  (gic_dat_last_i),
        .gic_cmd_vld_i   (gic_cmd_vld_i),
        .gic_dat_rdy_o   (gic_dat_rdy_o),
        .mon_dat_i       (mon_dat_i),
        .mon_dat_vld_i   (mon_dat_vld_i),
        .mon_dat_last_i  (mon_dat_last_i),
        .mon_dat_rdy_o   (mon_dat_rdy_o)
    );

    // ----------------------------------------
    // Clock and run limit
    // ----------------------------------------
    initial OffClk = 1'b0;
    always #4 OffClk = ~OffClk;

    always @(posedge OffClk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Run hit the cycle limit of %0d before the tests finished", cycle_cnt);
            $display("Some tests failed");
            $fatal(1, "Timeout");
        end
    end

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
            $display("Some tests failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // ----------------------------------------
    // Inbound helpers
    // ----------------------------------------

    // Host side, each beat held until inbound ready
    task automatic send_inbound(input itf_pkg::itf_dat_t beats[$], input logic isa);
        @(posedge OffClk);
        foreach (beats[i]) begin
            off_dat_vld_i  <= 1'b1;
            off_dat_i      <= beats[i];
            off_dat_last_i <= (i == beats.size() - 1);
            off_isa_vld_i  <= isa;
            do begin
                @(negedge OffClk);
            end while (!off_in_rdy_o);
            @(posedge OffClk);
            in_cnt++;
        end
        off_dat_vld_i  <= 1'b0;
        off_dat_last_i <= 1'b0;
    endtask

    // Port ready must already be high
    task automatic collect_inbound(input itf_pkg::itf_dat_t beats[$], input logic to_ccu);
        int n;
        n = 0;
        while (n < beats.size()) begin
            @(negedge OffClk);
            if (to_ccu) begin
                compare("gic_dat_vld_o", 0, gic_dat_vld_o);
                if (ccu_dat_vld_o) begin
                    compare("ccu_dat_o", beats[n], ccu_dat_o);
                    compare("ccu_dat_last_o", n == beats.size() - 1, ccu_dat_last_o);
                    compare("gic_dat_o", 0, gic_dat_o);
                    n++;
                end
            end else begin
                compare("ccu_dat_vld_o", 0, ccu_dat_vld_o);
                if (gic_dat_vld_o) begin
                    compare("gic_dat_o", beats[n], gic_dat_o);
                    compare("gic_dat_last_o", n == beats.size() - 1, gic_dat_last_o);
                    compare("ccu_dat_o", 0, ccu_dat_o);
                    n++;
                end
            end
        end
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic check_reset_state();
        @(negedge OffClk);
        compare("off_in_rdy_o", 0, off_in_rdy_o);
        compare("off_dat_vld_o", 0, off_dat_vld_o);
        compare("off_dat_oe_o", 0, off_dat_oe_o);
        compare("ccu_dat_vld_o", 0, ccu_dat_vld_o);
        compare("gic_dat_vld_o", 0, gic_dat_vld_o);
        compare("gic_dat_rdy_o", 0, gic_dat_rdy_o);
        compare("mon_dat_rdy_o", 0, mon_dat_rdy_o);
        compare("mon_state_o", 0, mon_state_o);
        compare("cfg_rdy_o", 0, cfg_rdy_o);
    endtask

    task automatic inbound_to_ccu();
        itf_pkg::itf_dat_t beats[$];
        repeat (3) beats.push_back($random(seed));
        @(posedge OffClk);
        ccu_dat_rdy_i <= 1'b1;
        gic_dat_rdy_i <= 1'b1;
        fork
            send_inbound(beats, 1'b1);
            collect_inbound(beats, 1'b1);
        join
    endtask

    task automatic inbound_backpressure();
        itf_pkg::itf_dat_t beats[$];
        repeat (6) beats.push_back($random(seed));
        @(posedge OffClk);
        gic_dat_rdy_i <= 1'b0;
        in_cnt = 0;
        fork
            send_inbound(beats, 1'b0);
            begin
                // Depth 4, beat 5 has to wait
                while (in_cnt < 4) begin
                    @(negedge OffClk);
                end
                repeat (4) begin
                    @(negedge OffClk);
                    compare("off_in_rdy_o", 0, off_in_rdy_o);
                    compare("accepted beat count", 4, in_cnt);
                    // Link still inbound, FIFO holding beats
                    compare("mon_state_o[5:4]", 1, mon_state_o[5:4]);
                    compare("mon_state_o[3:2] busy", 1, mon_state_o[3:2] != 0);
                end
                @(posedge OffClk);
                gic_dat_rdy_i <= 1'b1;
                collect_inbound(beats, 1'b0);
            end
        join
    endtask

    task automatic outbound_random_ready();
        itf_pkg::itf_dat_t beats[$];
        logic              cmd[$];
        int                i;
        int                cyc;
        logic              exp_vld;
        repeat (6) begin
            beats.push_back($random(seed));
            cmd.push_back(1'($random(seed)));
        end
        i = 0;
        cyc = 0;
        @(posedge OffClk);
        while (i < beats.size()) begin
            gic_dat_vld_i  <= 1'b1;
            gic_dat_i      <= beats[i];
            gic_dat_last_i <= (i == beats.size() - 1);
            gic_cmd_vld_i  <= cmd[i];
            off_dat_rdy_i  <= 1'($random(seed));
            byp_oe_i       <= 1'($random(seed));
            off_oe_i       <= 1'($random(seed));
            @(negedge OffClk);
            // Link turns outbound one edge after the request
            exp_vld = (cyc != 0);
            compare("off_dat_vld_o", exp_vld, off_dat_vld_o);
            compare("gic_dat_rdy_o", exp_vld & off_dat_rdy_i, gic_dat_rdy_o);
            compare("off_dat_oe_o", byp_oe_i ? off_oe_i : exp_vld, off_dat_oe_o);
            if (exp_vld) begin
                compare("off_dat_o", beats[i], off_dat_o);
                compare("off_cmd_vld_o", cmd[i], off_cmd_vld_o);
                compare("off_dat_last_o", i == beats.size() - 1, off_dat_last_o);
                if (off_dat_rdy_i) begin
                    i++;
                end
            end
            cyc++;
            @(posedge OffClk);
        end
        gic_dat_vld_i  <= 1'b0;
        gic_dat_last_i <= 1'b0;
        gic_cmd_vld_i  <= 1'b0;
        byp_oe_i       <= 1'b0;
        off_dat_rdy_i  <= 1'b0;
    endtask

    task automatic outbound_priority();
        itf_pkg::itf_dat_t mon_beats[$];
        itf_pkg::itf_dat_t gic_beats[$];
        itf_pkg::itf_dat_t exp_dat;
        int                mi;
        int                gi;
        int                oi;
        repeat (3) mon_beats.push_back($random(seed));
        repeat (3) gic_beats.push_back($random(seed));
        mi = 0;
        gi = 0;
        oi = 0;
        @(posedge OffClk);
        off_dat_rdy_i <= 1'b1;
        while (oi < 6) begin
            mon_dat_vld_i  <= (mi < 3);
            mon_dat_i      <= mon_beats[mi % 3];
            mon_dat_last_i <= (mi == 2);
            gic_dat_vld_i  <= (gi < 3);
            gic_dat_i      <= gic_beats[gi % 3];
            gic_dat_last_i <= (gi == 2);
            gic_cmd_vld_i  <= (gi < 3);
            @(negedge OffClk);
            compare("mon_dat_rdy_o & gic_dat_rdy_o", 0, mon_dat_rdy_o & gic_dat_rdy_o);
            if (off_dat_vld_o) begin
                // MON packet first, cmd flag only on GIC beats
                exp_dat = (oi < 3) ? mon_beats[oi] : gic_beats[oi - 3];
                compare("off_dat_o", exp_dat, off_dat_o);
                compare("off_cmd_vld_o", oi >= 3, off_cmd_vld_o);
                compare("off_dat_last_o", oi == 2 || oi == 5, off_dat_last_o);
                oi++;
            end
            if (mon_dat_vld_i && mon_dat_rdy_o) begin
                mi++;
            end
            if (gic_dat_vld_i && gic_dat_rdy_o) begin
                gi++;
            end
            @(posedge OffClk);
        end
        mon_dat_vld_i  <= 1'b0;
        mon_dat_last_i <= 1'b0;
        gic_dat_vld_i  <= 1'b0;
        gic_dat_last_i <= 1'b0;
        gic_cmd_vld_i  <= 1'b0;
        off_dat_rdy_i  <= 1'b0;
    endtask

    task automatic monitor_registers();
        itf_pkg::itf_cfg_rdy_t cfg_prev;
        itf_pkg::itf_ccu_mon_t st_prev;
        cfg_prev = ccu_cfg_rdy_i;
        st_prev = ccu_mon_state_i;
        repeat (8) begin
            @(posedge OffClk);
            ccu_cfg_rdy_i   <= itf_pkg::itf_cfg_rdy_t'($random(seed));
            ccu_mon_state_i <= itf_pkg::itf_ccu_mon_t'($random(seed));
            @(negedge OffClk);
            // Registers show the inputs from before this edge
            compare("cfg_rdy_o", cfg_prev, cfg_rdy_o);
            compare("mon_state_o[1:0]", st_prev, mon_state_o[1:0]);
            compare("mon_state_o[5:2]", 0, mon_state_o[5:2]);
            cfg_prev = ccu_cfg_rdy_i;
            st_prev = ccu_mon_state_i;
        end
        // Single MON beat, host holds it off
        @(posedge OffClk);
        mon_dat_vld_i  <= 1'b1;
        mon_dat_i      <= $random(seed);
        mon_dat_last_i <= 1'b1;
        off_dat_rdy_i  <= 1'b0;
        repeat (2) @(posedge OffClk);
        @(negedge OffClk);
        compare("mon_state_o[5:4]", 2, mon_state_o[5:4]);
        @(posedge OffClk);
        off_dat_rdy_i <= 1'b1;
        do begin
            @(negedge OffClk);
        end while (!mon_dat_rdy_o);
        @(posedge OffClk);
        mon_dat_vld_i  <= 1'b0;
        mon_dat_last_i <= 1'b0;
        off_dat_rdy_i  <= 1'b0;
        @(posedge OffClk);
        @(negedge OffClk);
        compare("mon_state_o[5:4]", 0, mon_state_o[5:4]);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        seed            = 32'hd96b_735f;
        rst_n           = 1'b0;
        off_dat_i       = '0;
        off_dat_vld_i   = 1'b0;
        off_dat_last_i  = 1'b0;
        off_isa_vld_i   = 1'b0;
        off_dat_rdy_i   = 1'b0;
        off_oe_i        = 1'b0;
        byp_oe_i        = 1'b0;
        ccu_cfg_rdy_i   = '0;
        ccu_mon_state_i = '0;
        ccu_dat_rdy_i   = 1'b0;
        gic_dat_rdy_i   = 1'b0;
        gic_dat_i       = '0;
        gic_dat_vld_i   = 1'b0;
        gic_dat_last_i  = 1'b0;
        gic_cmd_vld_i   = 1'b0;
        mon_dat_i       = '0;
        mon_dat_vld_i   = 1'b0;
        mon_dat_last_i  = 1'b0;
        repeat (2) @(posedge OffClk);
        rst_n <= 1'b1;

        check_reset_state();
        inbound_to_ccu();
        inbound_backpressure();
        outbound_random_ready();
        outbound_priority();
        monitor_registers();

        // Protocol properties of the bound checker
        if (i_itf_top.i_itf_assert.fail_cnt == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1, "%0d protocol checks failed", i_itf_top.i_itf_assert.fail_cnt);
        end
    end

endmodule

`default_nettype wire

//--- dv/itf_assert.sv
`default_nettype none

module itf_assert (
    input wire                OffClk,
    input wire                rst_n,
    input wire                off_dat_vld_o,
    input wire                off_dat_rdy_i,
    input itf_pkg::itf_dat_t  off_dat_o,
    input wire                off_in_rdy_o,
    input wire                ccu_dat_vld_o,
    input wire                gic_dat_vld_o
);

    // Count of failed properties
    int fail_cnt = 0;

    // ----------------------------------------
    // Off-chip outbound handshake
    // ----------------------------------------

    // Beat and data held until the host takes it
    out_hold: assert property (@(posedge OffClk) disable iff (!rst_n)
        off_dat_vld_o && !off_dat_rdy_i |=> off_dat_vld_o && $stable(off_dat_o))
        else begin
            fail_cnt++;
            $error("Off-chip beat dropped or changed before the host took it");
        end

    // Inbound ready never while a beat goes out to the host
    in_rdy_dir: assert property (@(posedge OffClk) disable iff (!rst_n)
        off_in_rdy_o |-> !off_dat_vld_o)
        else begin
            fail_cnt++;
            $error("Inbound ready high outside inbound operation");
        end

    // ----------------------------------------
    // Inbound steering
    // ----------------------------------------
    one_port: assert property (@(posedge OffClk) disable iff (!rst_n)
        !(ccu_dat_vld_o && gic_dat_vld_o))
        else begin
            fail_cnt++;
            $error("CCU and GIC valid high together");
        end

endmodule

bind itf_top itf_assert i_itf_assert (
    .OffClk        (OffClk),
    .rst_n         (rst_n),
    .off_dat_vld_o (off_dat_vld_o),
    .off_dat_rdy_i (off_dat_rdy_i),
    .off_dat_o     (off_dat_o),
    .off_in_rdy_o  (off_in_rdy_o),
    .ccu_dat_vld_o (ccu_dat_vld_o),
    .gic_dat_vld_o (gic_dat_vld_o)
);

`default_nettype wire

//--- verilog/itf_top.sv
`default_nettype none

`include "itf_macros.svh"

module itf_top (
    input  wire                    OffClk,
    input  wire                    rst_n,
    // Off-chip port
    input  itf_pkg::itf_dat_t      off_dat_i,
    input  wire                    off_dat_vld_i,
    input  wire                    off_dat_last_i,
    input  wire                    off_isa_vld_i,
    input  wire                    off_dat_rdy_i,
    input  wire                    off_oe_i,
    input  wire                    byp_oe_i,
    output itf_pkg::itf_dat_t      off_dat_o,
    output logic                   off_dat_vld_o,
    output logic                   off_dat_last_o,
    output logic                   off_cmd_vld_o,
    output logic                   off_in_rdy_o,
    output logic                   off_dat_oe_o,
    output itf_pkg::itf_mon_t      mon_state_o,
    output itf_pkg::itf_cfg_rdy_t  cfg_rdy_o,
    // CCU
    input  itf_pkg::itf_cfg_rdy_t  ccu_cfg_rdy_i,
    input  itf_pkg::itf_ccu_mon_t  ccu_mon_state_i,
    output itf_pkg::itf_dat_t      ccu_dat_o,
    output logic                   ccu_dat_vld_o,
    output logic                   ccu_dat_last_o,
    input  wire                    ccu_dat_rdy_i,
    // GIC inbound
    output itf_pkg::itf_dat_t      gic_dat_o,
    output logic                   gic_dat_vld_o,
    output logic                   gic_dat_last_o,
    input  wire                    gic_dat_rdy_i,
    // GIC outbound
    input  itf_pkg::itf_dat_t      gic_dat_i,
    input  wire                    gic_dat_vld_i,
    input  wire                    gic_dat_last_i,
    input  wire                    gic_cmd_vld_i,
    output logic                   gic_dat_rdy_o,
    // MON
    input  itf_pkg::itf_dat_t      mon_dat_i,
    input  wire                    mon_dat_vld_i,
    input  wire                    mon_dat_last_i,
    output logic                   mon_dat_rdy_o
);

    // FIFO side
    itf_pkg::itf_in_entry_t fifo_din;
    itf_pkg::itf_in_entry_t fifo_dout;
    logic                   fifo_push;
    logic                   fifo_pop;
    logic                   fifo_not_empty;
    logic                   fifo_full;
    // Link controller to outbound mux
    logic                   out_active;
    logic                   out_req;
    logic                   out_last_fire;

    // Entry packing {data, isa, last}
    assign fifo_din = {off_dat_i, off_isa_vld_i, off_dat_last_i};

    // ----------------------------------------
    // Control
    // ----------------------------------------
    itf_link_ctrl i_link_ctrl (
        .OffClk           (OffClk),
        .rst_n            (rst_n),
        .off_dat_vld_i    (off_dat_vld_i),
        .off_dat_last_i   (off_dat_last_i),
        .fifo_full_i      (fifo_full),
        .fifo_not_empty_i (fifo_not_empty),
        .out_req_i        (out_req),
        .out_last_fire_i  (out_last_fire),
        .ccu_cfg_rdy_i    (ccu_cfg_rdy_i),
        .ccu_mon_state_i  (ccu_mon_state_i),
        .off_in_rdy_o     (off_in_rdy_o),
        .fifo_push_o      (fifo_push),
        .out_active_o     (out_active),
        .mon_state_o      (mon_state_o),
        .cfg_rdy_o        (cfg_rdy_o)
    );

    // ----------------------------------------
    // Inbound path
    // ----------------------------------------
    itf_in_fifo #(
        .ADDR_WIDTH (`ITF_FIFO_AW)
    ) i_in_fifo (
        .OffClk      (OffClk),
        .rst_n       (rst_n),
        .push_i      (fifo_push),
        .din_i       (fifo_din),
        .pop_i       (fifo_pop),
        .dout_o      (fifo_dout),
        .not_empty_o (fifo_not_empty),
        .full_o      (fifo_full)
    );

    itf_in_steer i_in_steer (
        .head_i         (fifo_dout),
        .head_vld_i     (fifo_not_empty),
        .ccu_dat_rdy_i  (ccu_dat_rdy_i),
        .gic_dat_rdy_i  (gic_dat_rdy_i),
        .pop_o          (fifo_pop),
        .ccu_dat_o      (ccu_dat_o),
        .ccu_dat_vld_o  (ccu_dat_vld_o),
        .ccu_dat_last_o (ccu_dat_last_o),
        .gic_dat_o      (gic_dat_o),
        .gic_dat_vld_o  (gic_dat_vld_o),
        .gic_dat_last_o (gic_dat_last_o)
    );

    // ----------------------------------------
    // Outbound path
    // ----------------------------------------
    itf_out_mux i_out_mux (
        .OffClk          (OffClk),
        .rst_n           (rst_n),
        .out_active_i    (out_active),
        .byp_oe_i        (byp_oe_i),
        .off_oe_i        (off_oe_i),
        .off_dat_rdy_i   (off_dat_rdy_i),
        .gic_dat_i       (gic_dat_i),
        .gic_dat_vld_i   (gic_dat_vld_i),
        .gic_dat_last_i  (gic_dat_last_i),
        .gic_cmd_vld_i   (gic_cmd_vld_i),
        .mon_dat_i       (mon_dat_i),
        .mon_dat_vld_i   (mon_dat_vld_i),
        .mon_dat_last_i  (mon_dat_last_i),
        .off_dat_o       (off_dat_o),
        .off_dat_vld_o   (off_dat_vld_o),
        .off_dat_last_o  (off_dat_last_o),
        .off_cmd_vld_o   (off_cmd_vld_o),
        .off_dat_oe_o    (off_dat_oe_o),
        .gic_dat_rdy_o   (gic_dat_rdy_o),
        .mon_dat_rdy_o   (mon_dat_rdy_o),
        .out_req_o       (out_req),
        .out_last_fire_o (out_last_fire)
    );

endmodule

`default_nettype wire

//--- verilog/itf_out_mux.sv
`default_nettype none

module itf_out_mux (
    input  wire                OffClk,
    input  wire                rst_n,
    input  wire                out_active_i,
    input  wire                byp_oe_i,
    input  wire                off_oe_i,
    input  wire                off_dat_rdy_i,
    // GIC source
    input  itf_pkg::itf_dat_t  gic_dat_i,
    input  wire                gic_dat_vld_i,
    input  wire                gic_dat_last_i,
    input  wire                gic_cmd_vld_i,
    // MON source
    input  itf_pkg::itf_dat_t  mon_dat_i,
    input  wire                mon_dat_vld_i,
    input  wire                mon_dat_last_i,
    // Off-chip side
    output itf_pkg::itf_dat_t  off_dat_o,
    output logic               off_dat_vld_o,
    output logic               off_dat_last_o,
    output logic               off_cmd_vld_o,
    output logic               off_dat_oe_o,
    output logic               gic_dat_rdy_o,
    output logic               mon_dat_rdy_o,
    output logic               out_req_o,
    output logic               out_last_fire_o
);

    logic lock_q;
    logic grant_mon_q;
    logic sel_mon;
    logic fire;

    // ----------------------------------------
    // Arbitration
    // ----------------------------------------

    // MON first, held once a beat is on the port
    assign sel_mon = lock_q ? grant_mon_q : mon_dat_vld_i;

    always_ff @(posedge OffClk or negedge rst_n) begin
        if (!rst_n) begin
            lock_q      <= 1'b0;
            grant_mon_q <= 1'b0;
        end else begin
            if (!lock_q) begin
                grant_mon_q <= sel_mon;
            end
            if (out_last_fire_o) begin
                lock_q <= 1'b0;
            end else if (off_dat_vld_o) begin
                lock_q <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Datapath, zero latency
    // ----------------------------------------

    assign off_dat_vld_o  = out_active_i & (sel_mon ? mon_dat_vld_i : gic_dat_vld_i);
    assign off_dat_o      = out_active_i ? (sel_mon ? mon_dat_i : gic_dat_i) : '0;
    assign off_dat_last_o = out_active_i & (sel_mon ? mon_dat_last_i : gic_dat_last_i);
    // Cmd flag only exists on GIC traffic
    assign off_cmd_vld_o  = out_active_i & ~sel_mon & gic_cmd_vld_i;

    // Host ready goes back to the granted source only
    assign mon_dat_rdy_o = out_active_i & sel_mon & off_dat_rdy_i;
    assign gic_dat_rdy_o = out_active_i & ~sel_mon & off_dat_rdy_i;

    assign fire            = off_dat_vld_o & off_dat_rdy_i;
    assign out_last_fire_o = fire & off_dat_last_o;
    assign out_req_o       = gic_dat_vld_i | mon_dat_vld_i;

    // Bypass hands the pad direction to the host
    assign off_dat_oe_o = byp_oe_i ? off_oe_i : off_dat_vld_o;

endmodule

`default_nettype wire

//--- verilog/itf_in_steer.sv
`default_nettype none

module itf_in_steer (
    input  itf_pkg::itf_in_entry_t  head_i,
    input  wire                     head_vld_i,
    input  wire                     ccu_dat_rdy_i,
    input  wire                     gic_dat_rdy_i,
    output logic                    pop_o,
    // Instruction port
    output itf_pkg::itf_dat_t       ccu_dat_o,
    output logic                    ccu_dat_vld_o,
    output logic                    ccu_dat_last_o,
    // Global buffer port
    output itf_pkg::itf_dat_t       gic_dat_o,
    output logic                    gic_dat_vld_o,
    output logic                    gic_dat_last_o
);

    itf_pkg::itf_dat_t head_dat;
    logic              head_isa;
    logic              head_last;

    // ----------------------------------------
    // Entry fields
    // ----------------------------------------

    // Same packing as the push side, {data, isa, last}
    assign head_dat  = head_i[$bits(head_i)-1:2];
    assign head_isa  = head_i[1];
    assign head_last = head_i[0];

    // ----------------------------------------
    // Port select
    // ----------------------------------------

    // ISA beats feed the CCU
    assign ccu_dat_o      = head_isa ? head_dat : '0;
    assign ccu_dat_vld_o  = head_isa & head_vld_i;
    assign ccu_dat_last_o = head_isa & head_last;

    // Everything else to the global buffer
    assign gic_dat_o      = head_isa ? '0 : head_dat;
    assign gic_dat_vld_o  = ~head_isa & head_vld_i;
    assign gic_dat_last_o = ~head_isa & head_last;

    // Only the selected port can take the head
    assign pop_o = (ccu_dat_vld_o & ccu_dat_rdy_i) | (gic_dat_vld_o & gic_dat_rdy_i);

endmodule

`default_nettype wire

//--- verilog/itf_in_fifo.sv
`default_nettype none

`include "itf_macros.svh"

module itf_in_fifo #(
    parameter int unsigned ADDR_WIDTH = `ITF_FIFO_AW
) (
    input  wire                     OffClk,
    input  wire                     rst_n,
    input  wire                     push_i,
    input  itf_pkg::itf_in_entry_t  din_i,
    input  wire                     pop_i,
    output itf_pkg::itf_in_entry_t  dout_o,
    output logic                    not_empty_o,
    output logic                    full_o
);

    localparam int unsigned DEPTH = 2 ** ADDR_WIDTH;
    localparam logic [ADDR_WIDTH:0] FULL_CNT = (ADDR_WIDTH + 1)'(DEPTH);

    itf_pkg::itf_in_entry_t mem [DEPTH];

    logic [ADDR_WIDTH-1:0] wr_ptr_q;
    logic [ADDR_WIDTH-1:0] rd_ptr_q;
    logic [ADDR_WIDTH:0]   count_q;
    logic                  do_push;
    logic                  do_pop;

    // ----------------------------------------
    // Flags and qualified strobes
    // ----------------------------------------

    assign not_empty_o = (count_q != '0);
    assign full_o      = (count_q == FULL_CNT);

    // Push on full and pop on empty are dropped
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & not_empty_o;

    // Head is visible without a read strobe
    assign dout_o = mem[rd_ptr_q];

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    always_ff @(posedge OffClk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= din_i;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge OffClk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // Occupancy, unchanged on simultaneous push and pop
    always_ff @(posedge OffClk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/itf_link_ctrl.sv
`default_nettype none

module itf_link_ctrl (
    input  wire                    OffClk,
    input  wire                    rst_n,
    // Inbound handshake from the host
    input  wire                    off_dat_vld_i,
    input  wire                    off_dat_last_i,
    // Inbound FIFO status
    input  wire                    fifo_full_i,
    input  wire                    fifo_not_empty_i,
    // Outbound side
    input  wire                    out_req_i,
    input  wire                    out_last_fire_i,
    // CCU status
    input  itf_pkg::itf_cfg_rdy_t  ccu_cfg_rdy_i,
    input  itf_pkg::itf_ccu_mon_t  ccu_mon_state_i,
    output logic                   off_in_rdy_o,
    output logic                   fifo_push_o,
    output logic                   out_active_o,
    output itf_pkg::itf_mon_t      mon_state_o,
    output itf_pkg::itf_cfg_rdy_t  cfg_rdy_o
);

    itf_pkg::link_state_e state_q;
    itf_pkg::link_state_e state_d;
    logic                 in_last_fire;
    logic [1:0]           fifo_busy;

    // ----------------------------------------
    // Direction FSM
    // ----------------------------------------

    // Inbound packet ends when its last beat is taken
    assign in_last_fire = off_dat_vld_i & off_in_rdy_o & off_dat_last_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            itf_pkg::LINK_IDLE: begin
                // Host wins over outbound sources
                if (off_dat_vld_i) begin
                    state_d = itf_pkg::LINK_IN2CHIP;
                end else if (out_req_i) begin
                    state_d = itf_pkg::LINK_OUT2OFF;
                end
            end
            itf_pkg::LINK_IN2CHIP: begin
                if (in_last_fire) begin
                    state_d = itf_pkg::LINK_IDLE;
                end
            end
            itf_pkg::LINK_OUT2OFF: begin
                if (out_last_fire_i) begin
                    state_d = itf_pkg::LINK_IDLE;
                end
            end
            default: begin
                state_d = itf_pkg::LINK_IDLE;
            end
        endcase
    end

    always_ff @(posedge OffClk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= itf_pkg::LINK_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Accept only while inbound and room left
    assign off_in_rdy_o = (state_q == itf_pkg::LINK_IN2CHIP) & ~fifo_full_i;
    assign fifo_push_o  = off_dat_vld_i & off_in_rdy_o;
    assign out_active_o = (state_q == itf_pkg::LINK_OUT2OFF);

    // ----------------------------------------
    // Status registers
    // ----------------------------------------

    // Code 1 while the FIFO still drains
    assign fifo_busy = {1'b0, fifo_not_empty_i};

    always_ff @(posedge OffClk or negedge rst_n) begin
        if (!rst_n) begin
            mon_state_o <= '0;
            cfg_rdy_o   <= '0;
        end else begin
            mon_state_o <= {state_q, fifo_busy, ccu_mon_state_i};
            cfg_rdy_o   <= ccu_cfg_rdy_i;
        end
    end

endmodule

`default_nettype wire

//--- verilog/itf_pkg.sv
`default_nettype none

`include "itf_macros.svh"

package itf_pkg;

    // One beat on the data port
    typedef logic [`ITF_PORT_WIDTH-1:0] itf_dat_t;

    // Config-ready lanes
    typedef logic [`ITF_OPNUM-1:0] itf_cfg_rdy_t;

    // CCU state as reported by the core
    typedef logic [`ITF_CCU_MON_W-1:0] itf_ccu_mon_t;

    // Monitor word: link state, FIFO busy code, CCU state
    typedef logic [2+2+`ITF_CCU_MON_W-1:0] itf_mon_t;

    // Inbound FIFO entry, packed as {data, isa, last}
    typedef logic [`ITF_PORT_WIDTH+1:0] itf_in_entry_t;

    // Direction of the half-duplex link
    typedef enum logic [1:0] {
        LINK_IDLE    = 2'd0,
        LINK_IN2CHIP = 2'd1,
        LINK_OUT2OFF = 2'd2
    } link_state_e;

endpackage

`default_nettype wire

//--- verilog/itf_macros.svh
`ifndef ITF_MACROS_SVH
`define ITF_MACROS_SVH

// ----------------------------------------
// Off-chip link widths and depths
// ----------------------------------------

// Width of one data beat on the parallel port
`define ITF_PORT_WIDTH 32

// Config-ready lanes from the CCU
`define ITF_OPNUM 5

// Inbound FIFO address bits, depth is 2**AW
`define ITF_FIFO_AW 2

// CCU state field reported in the monitor word
`define ITF_CCU_MON_W 2

`endif
